//--- common/cs_consts.svh
// Entry values index the 256-entry control store. CS_OP_0F_* macros hold the second opcode byte
`ifndef CS_CONSTS_SVH
`define CS_CONSTS_SVH

// Fixed entry when the 3-prefix flag is set
`define CS_PREFIX3_ENTRY 8'h91
`define CS_UQ_CREDITS 4

// ModRM
`define CS_MOD_REG 2'b11
`define CS_EXT_ADD 3'd0
`define CS_EXT_OR 3'd1
`define CS_EXT_AND 3'd4
`define CS_EXT_INC 3'd0
`define CS_EXT_CALL 3'd2
`define CS_EXT_JMP 3'd4
`define CS_EXT_PUSH 3'd6
`define CS_EXT_SHL 3'd4
`define CS_EXT_SAR 3'd7

// Register forms match on the upper five bits only
`define CS_OP_REG_MASK 8'hF8

// ALU opcodes
`define CS_OP_ADD_EB_GB 8'h00
`define CS_OP_ADD_EV_GV 8'h01
`define CS_OP_ADD_GB_EB 8'h02
`define CS_OP_ADD_GV_EV 8'h03
`define CS_OP_ADD_AL_IB 8'h04
`define CS_OP_ADD_AX_IV 8'h05
`define CS_OP_OR_EB_GB 8'h08
`define CS_OP_OR_EV_GV 8'h09
`define CS_OP_OR_GB_EB 8'h0A
`define CS_OP_OR_GV_EV 8'h0B
`define CS_OP_OR_AL_IB 8'h0C
`define CS_OP_OR_AX_IV 8'h0D
`define CS_OP_AND_EB_GB 8'h20
`define CS_OP_AND_EV_GV 8'h21
`define CS_OP_AND_GB_EB 8'h22
`define CS_OP_AND_GV_EV 8'h23
`define CS_OP_AND_AL_IB 8'h24
`define CS_OP_AND_AX_IV 8'h25
`define CS_OP_GRP1_B 8'h80
`define CS_OP_GRP1_V 8'h81
`define CS_OP_GRP1_SV 8'h83

// Control transfer opcodes
`define CS_OP_CALL_NEAR 8'hE8
`define CS_OP_CALL_FAR 8'h9A
`define CS_OP_IRET 8'hCF
`define CS_OP_JA_SHORT 8'h77
`define CS_OP_JNE_SHORT 8'h75
`define CS_OP_0F_JA_NEAR 8'h87
`define CS_OP_0F_JNE_NEAR 8'h85
`define CS_OP_JMP_SHORT 8'hEB
`define CS_OP_JMP_NEAR 8'hE9
`define CS_OP_JMP_FAR 8'hEA
`define CS_OP_RET_NEAR 8'hC3
`define CS_OP_RET_FAR 8'hCB
`define CS_OP_RET_NEAR_IW 8'hC2
`define CS_OP_RET_FAR_IW 8'hCA
`define CS_OP_GRP5 8'hFF

// Stack opcodes
`define CS_OP_PUSH_R 8'h50
`define CS_OP_POP_R 8'h58
`define CS_OP_PUSH_IV 8'h68
`define CS_OP_PUSH_IB 8'h6A
`define CS_OP_POP_EV 8'h8F
`define CS_OP_PUSH_ES 8'h06
`define CS_OP_POP_ES 8'h07
`define CS_OP_PUSH_CS 8'h0E
`define CS_OP_PUSH_SS 8'h16
`define CS_OP_POP_SS 8'h17
`define CS_OP_PUSH_DS 8'h1E
`define CS_OP_POP_DS 8'h1F
`define CS_OP_0F_PUSH_FS 8'hA0
`define CS_OP_0F_POP_FS 8'hA1
`define CS_OP_0F_PUSH_GS 8'hA8
`define CS_OP_0F_POP_GS 8'hA9

// Halt and exception opcodes
`define CS_OP_HLT 8'hF4
`define CS_OP_EXC_AA 8'hAA
`define CS_OP_INT3 8'hCC
`define CS_OP_EXC_DD 8'hDD

// Shift and increment opcodes
`define CS_OP_INC_R 8'h40
`define CS_OP_GRP4 8'hFE
`define CS_OP_SHF_B1 8'hD0
`define CS_OP_SHF_V1 8'hD1
`define CS_OP_SHF_BCL 8'hD2
`define CS_OP_SHF_VCL 8'hD3
`define CS_OP_SHF_BI 8'hC0
`define CS_OP_SHF_VI 8'hC1

// ALU entries
`define CS_ENTRY_ADD_AL_IB 8'h00
`define CS_ENTRY_ADD_AX_IV 8'h01
`define CS_ENTRY_ADD_EB_IB 8'h02
`define CS_ENTRY_ADD_EV_IV 8'h03
`define CS_ENTRY_ADD_EV_IB 8'h04
`define CS_ENTRY_ADD_EB_GB 8'h05
`define CS_ENTRY_ADD_EV_GV 8'h06
`define CS_ENTRY_ADD_GB_EB 8'h07
`define CS_ENTRY_ADD_GV_EV 8'h08
`define CS_ENTRY_AND_AL_IB 8'h09
`define CS_ENTRY_AND_AX_IV 8'h0A
`define CS_ENTRY_AND_EB_IB 8'h0B
`define CS_ENTRY_AND_EV_IV 8'h0C
`define CS_ENTRY_AND_EV_IB 8'h0D
`define CS_ENTRY_AND_EB_GB 8'h0E
`define CS_ENTRY_AND_EV_GV 8'h0F
`define CS_ENTRY_AND_GB_EB 8'h10
`define CS_ENTRY_AND_GV_EV 8'h11
`define CS_ENTRY_OR_AL_IB 8'h3D
`define CS_ENTRY_OR_AX_IV 8'h3E
`define CS_ENTRY_OR_EB_IB 8'h3F
`define CS_ENTRY_OR_EV_IV 8'h40
`define CS_ENTRY_OR_EV_IB 8'h41
`define CS_ENTRY_OR_EB_GB 8'h42
`define CS_ENTRY_OR_EV_GV 8'h43
`define CS_ENTRY_OR_GB_EB 8'h44
`define CS_ENTRY_OR_GV_EV 8'h45

// Control transfer entries
`define CS_ENTRY_CALL_NEAR 8'h12
`define CS_ENTRY_CALL_IND 8'h14
`define CS_ENTRY_CALL_FAR 8'h16
`define CS_ENTRY_JA_SHORT 8'h25
`define CS_ENTRY_JNE_SHORT 8'h26
`define CS_ENTRY_JA_NEAR 8'h27
`define CS_ENTRY_JNE_NEAR 8'h28
`define CS_ENTRY_JMP_SHORT 8'h29
`define CS_ENTRY_JMP_NEAR 8'h2A
`define CS_ENTRY_JMP_IND 8'h2B
`define CS_ENTRY_JMP_FAR 8'h2C
`define CS_ENTRY_RET_NEAR 8'h67
`define CS_ENTRY_RET_FAR 8'h69
`define CS_ENTRY_RET_NEAR_IW 8'h6C
`define CS_ENTRY_RET_FAR_IW 8'h6E
// IRET sits near the end of the store for its long sequence
`define CS_ENTRY_IRET 8'h8D

// Stack entries
`define CS_ENTRY_POP_EV_MEM 8'h4C
`define CS_ENTRY_POP_EV_REG 8'h4E
`define CS_ENTRY_POP_R 8'h4F
`define CS_ENTRY_POP_DS 8'h50
`define CS_ENTRY_POP_ES 8'h51
`define CS_ENTRY_POP_SS 8'h52
`define CS_ENTRY_POP_FS 8'h53
`define CS_ENTRY_POP_GS 8'h54
`define CS_ENTRY_PUSH_EV_MEM 8'h57
`define CS_ENTRY_PUSH_EV_REG 8'h59
`define CS_ENTRY_PUSH_R 8'h5A
`define CS_ENTRY_PUSH_IB 8'h5B
`define CS_ENTRY_PUSH_IV 8'h5C
`define CS_ENTRY_PUSH_CS 8'h5D
`define CS_ENTRY_PUSH_SS 8'h5E
`define CS_ENTRY_PUSH_DS 8'h5F
`define CS_ENTRY_PUSH_ES 8'h60
`define CS_ENTRY_PUSH_FS 8'h61
`define CS_ENTRY_PUSH_GS 8'h62

// Halt and exception entries
`define CS_ENTRY_HLT 8'h20
`define CS_ENTRY_EXC_AA 8'h81
`define CS_ENTRY_EXC_DD 8'h85
`define CS_ENTRY_INT3 8'h89

// Shift and increment entries
`define CS_ENTRY_INC_EB 8'h21
`define CS_ENTRY_INC_EV 8'h22
`define CS_ENTRY_INC_R 8'h23
`define CS_ENTRY_SHL_EB_1 8'h71
`define CS_ENTRY_SHL_EB_CL 8'h72
`define CS_ENTRY_SHL_EB_IB 8'h73
`define CS_ENTRY_SHL_EV_1 8'h74
`define CS_ENTRY_SHL_EV_CL 8'h75
`define CS_ENTRY_SHL_EV_IB 8'h76
`define CS_ENTRY_SAR_EB_1 8'h77
`define CS_ENTRY_SAR_EB_CL 8'h78
`define CS_ENTRY_SAR_EB_IB 8'h79
`define CS_ENTRY_SAR_EV_1 8'h7A
`define CS_ENTRY_SAR_EV_CL 8'h7B
`define CS_ENTRY_SAR_EV_IB 8'h7C

`endif

//--- common/cs_pkg.sv
// Types only. The request packs to 31 bits and the issued micro-op to 20 bits
package cs_pkg;

	typedef logic [7:0] opcode_t;
	typedef logic [7:0] uaddr_t;
	typedef logic [2:0] modrm_ext_t;
	typedef logic [1:0] modrm_mod_t;

	typedef struct packed {
		opcode_t    opcode1;
		// Second byte counts only when has_op2 is set
		opcode_t    opcode2;
		logic       has_op2;
		modrm_ext_t mod_ext;
		modrm_mod_t mod;
		logic       has_prefix3;
		uaddr_t     uop_ptr;
	} decode_req_t;

	// Instruction specific controls outside the control store
	typedef struct packed {
		logic op_br;
		logic op_fptr;
		logic op_fptr_s;
		logic op_jmp_reg;
		logic op_pop_reg;
		logic op_push_reg;
		logic op_halt;
		logic op_shf_1;
		logic op_excp;
		logic seg_pop;
		logic op_call;
		logic op_ret_imm;
	} op_flags_t;

	typedef struct packed {
		uaddr_t    uop_addr;
		op_flags_t flags;
	} uop_t;

endpackage

//--- decode/entry_addr_decode.sv
// Combinational. Overlapping matches OR together and an unmatched request gives entry 0
`timescale 1ns/1ps
`include "cs_consts.svh"

module entry_addr_decode (
	input  cs_pkg::decode_req_t req,
	output cs_pkg::uaddr_t      entry
);
	import cs_pkg::*;

	opcode_t    op1;
	opcode_t    op2;
	modrm_ext_t ext;
	logic       two;
	logic       is_reg;
	logic       ff_push;

	function automatic uaddr_t pick(input logic hit, input uaddr_t addr);
		return {$bits(uaddr_t){hit}} & addr;
	endfunction

	assign op1 = req.opcode1;
	assign op2 = req.opcode2;
	assign ext = req.mod_ext;
	assign two = req.has_op2;
	assign is_reg = (req.mod == `CS_MOD_REG);
	assign ff_push = (op1 == `CS_OP_GRP5) && (ext == `CS_EXT_PUSH);

	always_comb begin
		entry = '0;
		// ALU
		entry |= pick(op1 == `CS_OP_ADD_AL_IB, `CS_ENTRY_ADD_AL_IB);
		entry |= pick(op1 == `CS_OP_ADD_AX_IV, `CS_ENTRY_ADD_AX_IV);
		entry |= pick(op1 == `CS_OP_GRP1_B && ext == `CS_EXT_ADD, `CS_ENTRY_ADD_EB_IB);
		entry |= pick(op1 == `CS_OP_GRP1_V && ext == `CS_EXT_ADD, `CS_ENTRY_ADD_EV_IV);
		entry |= pick(op1 == `CS_OP_GRP1_SV && ext == `CS_EXT_ADD, `CS_ENTRY_ADD_EV_IB);
		entry |= pick(op1 == `CS_OP_ADD_EB_GB, `CS_ENTRY_ADD_EB_GB);
		entry |= pick(op1 == `CS_OP_ADD_EV_GV, `CS_ENTRY_ADD_EV_GV);
		entry |= pick(op1 == `CS_OP_ADD_GB_EB, `CS_ENTRY_ADD_GB_EB);
		entry |= pick(op1 == `CS_OP_ADD_GV_EV, `CS_ENTRY_ADD_GV_EV);
		entry |= pick(op1 == `CS_OP_AND_AL_IB, `CS_ENTRY_AND_AL_IB);
		entry |= pick(op1 == `CS_OP_AND_AX_IV, `CS_ENTRY_AND_AX_IV);
		entry |= pick(op1 == `CS_OP_GRP1_B && ext == `CS_EXT_AND, `CS_ENTRY_AND_EB_IB);
		entry |= pick(op1 == `CS_OP_GRP1_V && ext == `CS_EXT_AND, `CS_ENTRY_AND_EV_IV);
		entry |= pick(op1 == `CS_OP_GRP1_SV && ext == `CS_EXT_AND, `CS_ENTRY_AND_EV_IB);
		entry |= pick(op1 == `CS_OP_AND_EB_GB, `CS_ENTRY_AND_EB_GB);
		entry |= pick(op1 == `CS_OP_AND_EV_GV, `CS_ENTRY_AND_EV_GV);
		entry |= pick(op1 == `CS_OP_AND_GB_EB, `CS_ENTRY_AND_GB_EB);
		entry |= pick(op1 == `CS_OP_AND_GV_EV, `CS_ENTRY_AND_GV_EV);
		entry |= pick(op1 == `CS_OP_OR_AL_IB, `CS_ENTRY_OR_AL_IB);
		entry |= pick(op1 == `CS_OP_OR_AX_IV, `CS_ENTRY_OR_AX_IV);
		entry |= pick(op1 == `CS_OP_GRP1_B && ext == `CS_EXT_OR, `CS_ENTRY_OR_EB_IB);
		entry |= pick(op1 == `CS_OP_GRP1_V && ext == `CS_EXT_OR, `CS_ENTRY_OR_EV_IV);
		entry |= pick(op1 == `CS_OP_GRP1_SV && ext == `CS_EXT_OR, `CS_ENTRY_OR_EV_IB);
		entry |= pick(op1 == `CS_OP_OR_EB_GB, `CS_ENTRY_OR_EB_GB);
		entry |= pick(op1 == `CS_OP_OR_EV_GV, `CS_ENTRY_OR_EV_GV);
		entry |= pick(op1 == `CS_OP_OR_GB_EB, `CS_ENTRY_OR_GB_EB);
		entry |= pick(op1 == `CS_OP_OR_GV_EV, `CS_ENTRY_OR_GV_EV);
		// Control transfer
		entry |= pick(op1 == `CS_OP_CALL_NEAR, `CS_ENTRY_CALL_NEAR);
		entry |= pick(op1 == `CS_OP_GRP5 && ext == `CS_EXT_CALL, `CS_ENTRY_CALL_IND);
		entry |= pick(op1 == `CS_OP_CALL_FAR, `CS_ENTRY_CALL_FAR);
		entry |= pick(op1 == `CS_OP_IRET, `CS_ENTRY_IRET);
		entry |= pick(op1 == `CS_OP_JA_SHORT, `CS_ENTRY_JA_SHORT);
		entry |= pick(op1 == `CS_OP_JNE_SHORT, `CS_ENTRY_JNE_SHORT);
		entry |= pick(two && op2 == `CS_OP_0F_JA_NEAR, `CS_ENTRY_JA_NEAR);
		entry |= pick(two && op2 == `CS_OP_0F_JNE_NEAR, `CS_ENTRY_JNE_NEAR);
		entry |= pick(op1 == `CS_OP_JMP_SHORT, `CS_ENTRY_JMP_SHORT);
		entry |= pick(op1 == `CS_OP_JMP_NEAR, `CS_ENTRY_JMP_NEAR);
		entry |= pick(op1 == `CS_OP_GRP5 && ext == `CS_EXT_JMP, `CS_ENTRY_JMP_IND);
		entry |= pick(op1 == `CS_OP_JMP_FAR, `CS_ENTRY_JMP_FAR);
		entry |= pick(op1 == `CS_OP_RET_NEAR, `CS_ENTRY_RET_NEAR);
		entry |= pick(op1 == `CS_OP_RET_FAR, `CS_ENTRY_RET_FAR);
		entry |= pick(op1 == `CS_OP_RET_NEAR_IW, `CS_ENTRY_RET_NEAR_IW);
		entry |= pick(op1 == `CS_OP_RET_FAR_IW, `CS_ENTRY_RET_FAR_IW);
		// Stack group with 8F and FF/6 split on register or memory operand
		entry |= pick(op1 == `CS_OP_POP_EV && !is_reg, `CS_ENTRY_POP_EV_MEM);
		entry |= pick(op1 == `CS_OP_POP_EV && is_reg, `CS_ENTRY_POP_EV_REG);
		entry |= pick((op1 & `CS_OP_REG_MASK) == `CS_OP_POP_R, `CS_ENTRY_POP_R);
		entry |= pick(op1 == `CS_OP_POP_DS, `CS_ENTRY_POP_DS);
		entry |= pick(op1 == `CS_OP_POP_ES, `CS_ENTRY_POP_ES);
		entry |= pick(op1 == `CS_OP_POP_SS, `CS_ENTRY_POP_SS);
		entry |= pick(two && op2 == `CS_OP_0F_POP_FS, `CS_ENTRY_POP_FS);
		entry |= pick(two && op2 == `CS_OP_0F_POP_GS, `CS_ENTRY_POP_GS);
		entry |= pick(ff_push && !is_reg, `CS_ENTRY_PUSH_EV_MEM);
		entry |= pick(ff_push && is_reg, `CS_ENTRY_PUSH_EV_REG);
		entry |= pick((op1 & `CS_OP_REG_MASK) == `CS_OP_PUSH_R, `CS_ENTRY_PUSH_R);
		entry |= pick(op1 == `CS_OP_PUSH_IB, `CS_ENTRY_PUSH_IB);
		entry |= pick(op1 == `CS_OP_PUSH_IV, `CS_ENTRY_PUSH_IV);
		entry |= pick(op1 == `CS_OP_PUSH_CS, `CS_ENTRY_PUSH_CS);
		entry |= pick(op1 == `CS_OP_PUSH_SS, `CS_ENTRY_PUSH_SS);
		entry |= pick(op1 == `CS_OP_PUSH_DS, `CS_ENTRY_PUSH_DS);
		entry |= pick(op1 == `CS_OP_PUSH_ES, `CS_ENTRY_PUSH_ES);
		entry |= pick(two && op2 == `CS_OP_0F_PUSH_FS, `CS_ENTRY_PUSH_FS);
		entry |= pick(two && op2 == `CS_OP_0F_PUSH_GS, `CS_ENTRY_PUSH_GS);
		// Halt and exception
		entry |= pick(op1 == `CS_OP_HLT, `CS_ENTRY_HLT);
		entry |= pick(op1 == `CS_OP_EXC_AA, `CS_ENTRY_EXC_AA);
		entry |= pick(op1 == `CS_OP_EXC_DD, `CS_ENTRY_EXC_DD);
		entry |= pick(op1 == `CS_OP_INT3, `CS_ENTRY_INT3);
		// Shift and increment
		entry |= pick(op1 == `CS_OP_GRP4, `CS_ENTRY_INC_EB);
		entry |= pick(op1 == `CS_OP_GRP5 && ext == `CS_EXT_INC, `CS_ENTRY_INC_EV);
		entry |= pick((op1 & `CS_OP_REG_MASK) == `CS_OP_INC_R, `CS_ENTRY_INC_R);
		entry |= pick(op1 == `CS_OP_SHF_B1 && ext == `CS_EXT_SHL, `CS_ENTRY_SHL_EB_1);
		entry |= pick(op1 == `CS_OP_SHF_BCL && ext == `CS_EXT_SHL, `CS_ENTRY_SHL_EB_CL);
		entry |= pick(op1 == `CS_OP_SHF_BI && ext == `CS_EXT_SHL, `CS_ENTRY_SHL_EB_IB);
		entry |= pick(op1 == `CS_OP_SHF_V1 && ext == `CS_EXT_SHL, `CS_ENTRY_SHL_EV_1);
		entry |= pick(op1 == `CS_OP_SHF_VCL && ext == `CS_EXT_SHL, `CS_ENTRY_SHL_EV_CL);
		entry |= pick(op1 == `CS_OP_SHF_VI && ext == `CS_EXT_SHL, `CS_ENTRY_SHL_EV_IB);
		entry |= pick(op1 == `CS_OP_SHF_B1 && ext == `CS_EXT_SAR, `CS_ENTRY_SAR_EB_1);
		entry |= pick(op1 == `CS_OP_SHF_BCL && ext == `CS_EXT_SAR, `CS_ENTRY_SAR_EB_CL);
		entry |= pick(op1 == `CS_OP_SHF_BI && ext == `CS_EXT_SAR, `CS_ENTRY_SAR_EB_IB);
		entry |= pick(op1 == `CS_OP_SHF_V1 && ext == `CS_EXT_SAR, `CS_ENTRY_SAR_EV_1);
		entry |= pick(op1 == `CS_OP_SHF_VCL && ext == `CS_EXT_SAR, `CS_ENTRY_SAR_EV_CL);
		entry |= pick(op1 == `CS_OP_SHF_VI && ext == `CS_EXT_SAR, `CS_ENTRY_SAR_EV_IB);
	end

endmodule

//--- decode/op_flag_decode.sv
// Combinational. Flags come from the opcode bytes, extension and mod only, never from the prefix
`timescale 1ns/1ps
`include "cs_consts.svh"

module op_flag_decode (
	input  cs_pkg::decode_req_t req,
	output cs_pkg::op_flags_t   flags
);
	import cs_pkg::*;

	opcode_t op1;
	opcode_t op2;
	logic    two;
	logic    is_reg;
	logic    ff_inc;
	logic    ff_call;
	logic    ff_jmp;
	logic    ff_push;
	logic    shf_by_1;

	assign op1 = req.opcode1;
	assign op2 = req.opcode2;
	assign two = req.has_op2;
	assign is_reg = (req.mod == `CS_MOD_REG);
	assign ff_inc = (op1 == `CS_OP_GRP5) && (req.mod_ext == `CS_EXT_INC);
	assign ff_call = (op1 == `CS_OP_GRP5) && (req.mod_ext == `CS_EXT_CALL);
	assign ff_jmp = (op1 == `CS_OP_GRP5) && (req.mod_ext == `CS_EXT_JMP);
	assign ff_push = (op1 == `CS_OP_GRP5) && (req.mod_ext == `CS_EXT_PUSH);

	// Shift by one in byte and full width
	assign shf_by_1 = (op1 == `CS_OP_SHF_B1 || op1 == `CS_OP_SHF_V1)
		&& (req.mod_ext == `CS_EXT_SHL || req.mod_ext == `CS_EXT_SAR);

	always_comb begin
		flags = '0;
		flags.op_br = op1 == `CS_OP_CALL_NEAR || ff_call || op1 == `CS_OP_CALL_FAR
			|| op1 == `CS_OP_IRET || op1 == `CS_OP_JA_SHORT || op1 == `CS_OP_JNE_SHORT
			|| (two && op2 == `CS_OP_0F_JA_NEAR) || (two && op2 == `CS_OP_0F_JNE_NEAR)
			|| op1 == `CS_OP_JMP_SHORT || op1 == `CS_OP_JMP_NEAR || ff_jmp
			|| op1 == `CS_OP_JMP_FAR || op1 == `CS_OP_RET_NEAR || op1 == `CS_OP_RET_FAR
			|| op1 == `CS_OP_RET_NEAR_IW || op1 == `CS_OP_RET_FAR_IW;
		// Far pointer operand and its jump-only variant
		flags.op_fptr = op1 == `CS_OP_JMP_FAR || op1 == `CS_OP_CALL_FAR;
		flags.op_fptr_s = op1 == `CS_OP_JMP_FAR;
		flags.op_jmp_reg = ff_jmp && is_reg;
		flags.op_pop_reg = op1 == `CS_OP_POP_EV && is_reg;
		flags.op_push_reg = ff_push && is_reg;
		flags.op_halt = op1 == `CS_OP_HLT;
		flags.op_shf_1 = op1 == `CS_OP_GRP4 || ff_inc || shf_by_1
			|| (op1 & `CS_OP_REG_MASK) == `CS_OP_INC_R;
		flags.op_excp = op1 == `CS_OP_EXC_AA || op1 == `CS_OP_INT3 || op1 == `CS_OP_EXC_DD;
		// Segment register pushes and pops alike
		flags.seg_pop = op1 == `CS_OP_POP_DS || op1 == `CS_OP_POP_ES || op1 == `CS_OP_POP_SS
			|| op1 == `CS_OP_PUSH_CS || op1 == `CS_OP_PUSH_SS || op1 == `CS_OP_PUSH_DS
			|| op1 == `CS_OP_PUSH_ES
			|| (two && op2 == `CS_OP_0F_POP_FS) || (two && op2 == `CS_OP_0F_POP_GS)
			|| (two && op2 == `CS_OP_0F_PUSH_FS) || (two && op2 == `CS_OP_0F_PUSH_GS);
		flags.op_call = ff_call;
		flags.op_ret_imm = op1 == `CS_OP_RET_NEAR_IW || op1 == `CS_OP_RET_FAR_IW;
	end

endmodule

//--- filelist.f
+incdir+common
common/cs_pkg.sv
decode/entry_addr_decode.sv
decode/op_flag_decode.sv
src/uop_issue.sv
src/cs_decode_top.sv
testbench/cs_checker.sv
testbench/tb_cs_decode.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass line.
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_cs_decode -f filelist.f -o tb_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

sim_output=$(./obj_dir/tb_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -qFx "PASS: all tests"; then
	exit 0
fi
echo "Pass line not found in the simulation output"
exit 1

//--- src/cs_decode_top.sv
// Decoders are combinational. Only uop_issue holds state, so the path from req to uop is one register
`timescale 1ns/1ps

module cs_decode_top (
	input  logic                clk,
	input  logic                rst,
	input  logic                req_valid,
	input  cs_pkg::decode_req_t req,
	output logic                req_ready,
	output logic                uop_valid,
	output cs_pkg::uop_t        uop,
	input  logic                credit_return
);
	import cs_pkg::*;

	uaddr_t    entry;
	op_flags_t flags;

	entry_addr_decode u_entry (
		.req   (req),
		.entry (entry)
	);

	op_flag_decode u_flags (
		.req   (req),
		.flags (flags)
	);

	uop_issue u_issue (
		.clk           (clk),
		.rst           (rst),
		.req_valid     (req_valid),
		.req           (req),
		.entry         (entry),
		.flags         (flags),
		.credit_return (credit_return),
		.req_ready     (req_ready),
		.uop_valid     (uop_valid),
		.uop           (uop)
	);

endmodule

//--- src/uop_issue.sv
// One cycle latency. The sender must hold req while req_ready is low and the queue returns one credit per entry
`timescale 1ns/1ps
`include "cs_consts.svh"

module uop_issue (
	input  logic                clk,
	input  logic                rst,
	input  logic                req_valid,
	input  cs_pkg::decode_req_t req,
	input  cs_pkg::uaddr_t      entry,
	input  cs_pkg::op_flags_t   flags,
	input  logic                credit_return,
	output logic                req_ready,
	output logic                uop_valid,
	output cs_pkg::uop_t        uop
);
	import cs_pkg::*;

	localparam int CRED_W = $clog2(`CS_UQ_CREDITS + 1);

	logic [CRED_W-1:0] credits;
	logic              accept;
	uaddr_t            base;
	uaddr_t            addr_next;

	assign req_ready = (credits != '0);
	assign accept = req_valid && req_ready;

	// Prefix override wins over the decoded entry
	assign base = req.has_prefix3 ? `CS_PREFIX3_ENTRY : entry;
	// 8-bit add wraps modulo 256
	assign addr_next = base + req.uop_ptr;

	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= CRED_W'(`CS_UQ_CREDITS);
			uop_valid <= 1'b0;
		end else begin
			uop_valid <= accept;
			case ({accept, credit_return})
				2'b10: credits <= credits - CRED_W'(1);
				2'b01: credits <= credits + CRED_W'(1);
				default: credits <= credits;
			endcase
		end
	end

	// Payload capture on acceptance
	always_ff @(posedge clk) begin
		if (accept) begin
			uop.uop_addr <= addr_next;
			uop.flags <= flags;
		end
	end

endmodule

//--- testbench/cs_checker.sv
// Samples on the rising edge and expects every uop one cycle after its acceptance. Call report once at the end
`timescale 1ns/1ps
`include "cs_consts.svh"

module cs_checker (
	input logic                clk,
	input logic                rst,
	input logic                req_valid,
	input cs_pkg::decode_req_t req,
	input logic                req_ready,
	input logic                uop_valid,
	input cs_pkg::uop_t        uop,
	input logic                credit_return
);
	import cs_pkg::*;

	uop_t expected_q[$];
	uop_t want;
	int   accepted = 0;
	int   issued = 0;
	int   mismatches = 0;
	int   other_errors = 0;
	int   credits = 0;
	int   outstanding = 0;

	// ADD, OR and AND rows share one layout of nine entries
	function automatic uaddr_t alu_base(input logic [2:0] sel);
		case (sel)
			3'd1: return `CS_ENTRY_OR_AL_IB;
			3'd4: return `CS_ENTRY_AND_AL_IB;
			default: return `CS_ENTRY_ADD_AL_IB;
		endcase
	endfunction

	function automatic uaddr_t first_byte_entry(input opcode_t op, input modrm_ext_t ext,
		input logic reg_op);
		uaddr_t e;
		e = '0;
		if (op[7:6] == 2'b00 && op[5:3] inside {3'd0, 3'd1, 3'd4} && op[2:0] <= 3'd5) begin
			e = alu_base(op[5:3]) + (op[2] ? uaddr_t'(op[1:0]) : uaddr_t'(op[1:0]) + 8'd5);
		end else if (op inside {8'h80, 8'h81, 8'h83}) begin
			if (ext inside {3'd0, 3'd1, 3'd4})
				e = alu_base(ext) + (op == 8'h80 ? 8'd2 : (op == 8'h81 ? 8'd3 : 8'd4));
		end else if (op inside {8'hD0, 8'hD1, 8'hD2, 8'hD3, 8'hC0, 8'hC1}) begin
			// Byte form first, then by 1, by CL and by immediate
			if (ext == 3'd4 || ext == 3'd7)
				e = (ext == 3'd4 ? `CS_ENTRY_SHL_EB_1 : `CS_ENTRY_SAR_EB_1)
					+ (op[0] ? 8'd3 : 8'd0) + (op[7:4] == 4'hD ? uaddr_t'(op[1]) : 8'd2);
		end else begin
			case (op)
				8'hE8: e = `CS_ENTRY_CALL_NEAR;
				8'h9A: e = `CS_ENTRY_CALL_FAR;
				8'hCF: e = `CS_ENTRY_IRET;
				8'h77: e = `CS_ENTRY_JA_SHORT;
				8'h75: e = `CS_ENTRY_JNE_SHORT;
				8'hEB: e = `CS_ENTRY_JMP_SHORT;
				8'hE9: e = `CS_ENTRY_JMP_NEAR;
				8'hEA: e = `CS_ENTRY_JMP_FAR;
				8'hC3: e = `CS_ENTRY_RET_NEAR;
				8'hCB: e = `CS_ENTRY_RET_FAR;
				8'hC2: e = `CS_ENTRY_RET_NEAR_IW;
				8'hCA: e = `CS_ENTRY_RET_FAR_IW;
				8'h68: e = `CS_ENTRY_PUSH_IV;
				8'h6A: e = `CS_ENTRY_PUSH_IB;
				8'h06: e = `CS_ENTRY_PUSH_ES;
				8'h07: e = `CS_ENTRY_POP_ES;
				8'h0E: e = `CS_ENTRY_PUSH_CS;
				8'h16: e = `CS_ENTRY_PUSH_SS;
				8'h17: e = `CS_ENTRY_POP_SS;
				8'h1E: e = `CS_ENTRY_PUSH_DS;
				8'h1F: e = `CS_ENTRY_POP_DS;
				8'h8F: e = reg_op ? `CS_ENTRY_POP_EV_REG : `CS_ENTRY_POP_EV_MEM;
				8'hF4: e = `CS_ENTRY_HLT;
				8'hAA: e = `CS_ENTRY_EXC_AA;
				8'hCC: e = `CS_ENTRY_INT3;
				8'hDD: e = `CS_ENTRY_EXC_DD;
				8'hFE: e = `CS_ENTRY_INC_EB;
				8'hFF: begin
					case (ext)
						3'd0: e = `CS_ENTRY_INC_EV;
						3'd2: e = `CS_ENTRY_CALL_IND;
						3'd4: e = `CS_ENTRY_JMP_IND;
						3'd6: e = reg_op ? `CS_ENTRY_PUSH_EV_REG : `CS_ENTRY_PUSH_EV_MEM;
						default: e = '0;
					endcase
				end
				default: begin
					if (op[7:3] == 5'b01000)
						e = `CS_ENTRY_INC_R;
					else if (op[7:3] == 5'b01010)
						e = `CS_ENTRY_PUSH_R;
					else if (op[7:3] == 5'b01011)
						e = `CS_ENTRY_POP_R;
				end
			endcase
		end
		return e;
	endfunction

	function automatic uaddr_t second_byte_entry(input opcode_t op);
		case (op)
			8'h85: return `CS_ENTRY_JNE_NEAR;
			8'h87: return `CS_ENTRY_JA_NEAR;
			8'hA0: return `CS_ENTRY_PUSH_FS;
			8'hA1: return `CS_ENTRY_POP_FS;
			8'hA8: return `CS_ENTRY_PUSH_GS;
			8'hA9: return `CS_ENTRY_POP_GS;
			default: return '0;
		endcase
	endfunction

	function automatic op_flags_t expected_flags(input decode_req_t r);
		op_flags_t  f;
		opcode_t    op;
		modrm_ext_t ext;
		logic       ff;
		logic       reg_op;
		op = r.opcode1;
		ext = r.mod_ext;
		ff = (op == 8'hFF);
		reg_op = (r.mod == 2'b11);
		f.op_br = op inside {8'hE8, 8'h9A, 8'hCF, 8'h77, 8'h75, 8'hEB, 8'hE9, 8'hEA,
			8'hC3, 8'hCB, 8'hC2, 8'hCA} || (ff && ext inside {3'd2, 3'd4})
			|| (r.has_op2 && r.opcode2 inside {8'h85, 8'h87});
		f.op_fptr = op inside {8'hEA, 8'h9A};
		f.op_fptr_s = (op == 8'hEA);
		f.op_jmp_reg = ff && ext == 3'd4 && reg_op;
		f.op_pop_reg = (op == 8'h8F) && reg_op;
		f.op_push_reg = ff && ext == 3'd6 && reg_op;
		f.op_halt = (op == 8'hF4);
		f.op_shf_1 = op == 8'hFE || (ff && ext == 3'd0) || op[7:3] == 5'b01000
			|| (op inside {8'hD0, 8'hD1} && ext inside {3'd4, 3'd7});
		f.op_excp = op inside {8'hAA, 8'hCC, 8'hDD};
		f.seg_pop = op inside {8'h06, 8'h07, 8'h0E, 8'h16, 8'h17, 8'h1E, 8'h1F}
			|| (r.has_op2 && r.opcode2 inside {8'hA0, 8'hA1, 8'hA8, 8'hA9});
		f.op_call = ff && ext == 3'd2;
		f.op_ret_imm = op inside {8'hC2, 8'hCA};
		return f;
	endfunction

	function automatic uop_t expected_uop(input decode_req_t r);
		uop_t   u;
		uaddr_t base;
		base = first_byte_entry(r.opcode1, r.mod_ext, r.mod == 2'b11);
		if (r.has_op2)
			base = base | second_byte_entry(r.opcode2);
		if (r.has_prefix3)
			base = `CS_PREFIX3_ENTRY;
		u.uop_addr = base + r.uop_ptr;
		u.flags = expected_flags(r);
		return u;
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			expected_q.delete();
			credits = `CS_UQ_CREDITS;
			outstanding = 0;
		end else begin
			if (req_ready !== (credits != 0)) begin
				mismatches++;
				$display("mismatch at %0t: req_ready is %b with %0d credits left",
					$time, req_ready, credits);
			end
			if (uop_valid) begin
				issued++;
				outstanding++;
				if (expected_q.size() == 0) begin
					other_errors++;
					$display("uop_valid at %0t without a request accepted one cycle before", $time);
				end else begin
					want = expected_q.pop_front();
					if (uop !== want) begin
						mismatches++;
						$display("mismatch at %0t: got addr %h flags %b, expected addr %h flags %b",
							$time, uop.uop_addr, uop.flags, want.uop_addr, want.flags);
					end
				end
			end else if (expected_q.size() != 0) begin
				other_errors++;
				$display("no micro-op came out one cycle after the acceptance before %0t", $time);
				expected_q.delete();
			end
			if (credit_return)
				outstanding--;
			if (outstanding > `CS_UQ_CREDITS) begin
				other_errors++;
				$display("queue holds %0d micro-ops at %0t, more than its credits", outstanding, $time);
			end
			if (req_valid && req_ready) begin
				accepted++;
				expected_q.push_back(expected_uop(req));
			end
			credits = credits - ((req_valid && req_ready) ? 1 : 0) + (credit_return ? 1 : 0);
		end
	end

	task automatic report(output int total);
		if (accepted != issued) begin
			other_errors++;
			$display("%0d requests were accepted but %0d micro-ops came out", accepted, issued);
		end
		total = mismatches + other_errors;
		$display("errors: %0d mismatches, %0d other errors, %0d micro-ops checked",
			mismatches, other_errors, issued);
	endtask

endmodule

//--- testbench/tb_cs_decode.sv
// Sweeps all first-byte opcodes with every extension, then random requests. The queue model stalls once
`timescale 1ns/1ps
`include "cs_consts.svh"

module tb_cs_decode;
	import cs_pkg::*;

	localparam int RANDOM_REQS = 400;
	localparam int STALL_REQS = 5;
	localparam logic [7:0] SECOND_BYTES [6] = '{8'h85, 8'h87, 8'hA0, 8'hA1, 8'hA8, 8'hA9};

	logic        clk = 1'b0;
	logic        rst;
	logic        req_valid;
	decode_req_t req;
	logic        req_ready;
	logic        uop_valid;
	uop_t        uop;
	logic        credit_return = 1'b0;

	decode_req_t stim[$];
	uop_t        held_uops[$];
	int          held_delay[$];
	logic        withhold;
	int          directed_count;
	int          cycles = 0;
	int          cycle_limit = 0;
	int          total_errors;
	int          timeout_errors;
	int          i;

	always #20 clk = ~clk;

	cs_decode_top u_dut (
		.clk           (clk),
		.rst           (rst),
		.req_valid     (req_valid),
		.req           (req),
		.req_ready     (req_ready),
		.uop_valid     (uop_valid),
		.uop           (uop),
		.credit_return (credit_return)
	);

	cs_checker u_chk (
		.clk           (clk),
		.rst           (rst),
		.req_valid     (req_valid),
		.req           (req),
		.req_ready     (req_ready),
		.uop_valid     (uop_valid),
		.uop           (uop),
		.credit_return (credit_return)
	);

	// Downstream queue frees its head after 0 to 6 cycles
	always @(posedge clk) begin
		if (rst) begin
			held_uops.delete();
			held_delay.delete();
			credit_return <= 1'b0;
		end else begin
			credit_return <= 1'b0;
			if (uop_valid) begin
				held_uops.push_back(uop);
				held_delay.push_back($urandom_range(6, 0));
			end
			if (!withhold && held_delay.size() != 0) begin
				if (held_delay[0] == 0) begin
					held_uops.delete(0);
					held_delay.delete(0);
					credit_return <= 1'b1;
				end else begin
					held_delay[0] = held_delay[0] - 1;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			u_chk.report(timeout_errors);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	function automatic decode_req_t make_req(input int op1, input int op2, input logic two,
		input int ext, input modrm_mod_t mod);
		decode_req_t r;
		r = '0;
		r.opcode1 = 8'(op1);
		r.opcode2 = 8'(op2);
		r.has_op2 = two;
		r.mod_ext = 3'(ext);
		r.mod = mod;
		return r;
	endfunction

	task automatic build_directed();
		int op;
		int ext;
		// Second byte mirrors the first so has_op2 gating is exercised too
		for (op = 0; op < 256; op++) begin
			for (ext = 0; ext < 8; ext++) begin
				stim.push_back(make_req(op, op, 1'b0, ext, 2'b00));
				stim.push_back(make_req(op, op, 1'b0, ext, `CS_MOD_REG));
			end
		end
		for (op = 0; op < 256; op++)
			stim.push_back(make_req(8'h0F, op, 1'b1, 0, `CS_MOD_REG));
	endtask

	task automatic build_random();
		decode_req_t r;
		int n;
		for (n = 0; n < RANDOM_REQS; n++) begin
			r.opcode1 = 8'($urandom);
			r.opcode2 = 8'($urandom);
			r.has_op2 = ($urandom_range(3, 0) == 0);
			if (r.has_op2) begin
				r.opcode1 = 8'h0F;
				if ($urandom_range(1, 0) == 1)
					r.opcode2 = SECOND_BYTES[$urandom_range(5, 0)];
			end
			r.mod_ext = 3'($urandom);
			r.mod = 2'($urandom);
			r.has_prefix3 = ($urandom_range(3, 0) == 0);
			r.uop_ptr = 8'($urandom);
			stim.push_back(r);
		end
	endtask

	task automatic send(input decode_req_t r);
		req <= r;
		req_valid <= 1'b1;
		do
			@(posedge clk);
		while (!req_ready);
	endtask

	task automatic wait_queue_empty();
		repeat (2) @(posedge clk);
		while (held_uops.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
	endtask

	// Queue keeps every credit, so the fifth push must wait
	task automatic stall_queue();
		int n;
		decode_req_t r;
		req_valid <= 1'b0;
		wait_queue_empty();
		withhold <= 1'b1;
		for (n = 0; n < STALL_REQS; n++) begin
			r = make_req(8'h50 + n, 0, 1'b0, n, 2'b00);
			if (n == `CS_UQ_CREDITS) begin
				req <= r;
				repeat (8) @(posedge clk);
				withhold <= 1'b0;
			end
			send(r);
		end
	endtask

	initial begin
		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		withhold = 1'b0;
		void'($urandom(32'h77010572));
		build_directed();
		directed_count = stim.size();
		build_random();
		cycle_limit = 40 * (stim.size() + STALL_REQS) + 200;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		for (i = 0; i < directed_count; i++)
			send(stim[i]);
		stall_queue();
		for (i = directed_count; i < stim.size(); i++)
			send(stim[i]);
		req_valid <= 1'b0;
		wait_queue_empty();
		u_chk.report(total_errors);
		if (total_errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
